//--- clock_pkg.sv
`default_nettype none

package clock_pkg;

	// Display geometry
	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;
	localparam int FIELD_W    = 6;

	// Default divide ratios for a 50 MHz clock
	localparam int CLK_PER_SEC_DEF  = 50_000_000;
	localparam int CLK_PER_SCAN_DEF = 5_000;
	localparam int CLK_PER_KEY_DEF  = 500_000;

	// ------------------------------
	// Shared types
	// ------------------------------
	typedef logic [FIELD_W-1:0]    field_t;
	typedef logic [3:0]            bcd_t;
	// Segments a..g, a is the MSB, active high
	typedef logic [SEG_W-1:0]      seg_t;
	// One bit per digit, low lights the digit
	typedef logic [NUM_DIGITS-1:0] digit_en_t;
	typedef logic [NUM_DIGITS-1:0] dp_mask_t;

	typedef enum logic {
		MODE_RUN = 1'b0,
		MODE_SET = 1'b1
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_t;

	// Inclusive wrap limits
	localparam field_t SEC_MAX  = 6'd59;
	localparam field_t MIN_MAX  = 6'd59;
	localparam field_t HOUR_MAX = 6'd23;

	// Dots between the field pairs in run mode
	localparam dp_mask_t DP_RUN = 6'b010101;

endpackage

`default_nettype wire

//--- tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
	parameter int DIV = 4
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_tick
);

	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] cnt;

	// Terminal count raises the pulse on the following cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else begin
			o_tick <= (cnt == CNT_W'(DIV - 1));
			if (cnt == CNT_W'(DIV - 1)) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- key_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module key_ctrl import clock_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  logic      i_btn_mode,
	input  logic      i_btn_pos,
	input  logic      i_btn_inc,
	input  logic      i_key_tick,
	output mode_t     o_mode,
	output logic      o_inc_sec,
	output logic      o_inc_min,
	output logic      o_inc_hour,
	output dp_mask_t  o_dp_mask
);

	// Sample order is {inc, pos, mode}
	logic [2:0] smp_new;
	logic [2:0] smp_old;
	logic       eval;
	logic       press_mode;
	logic       press_pos;
	logic       press_inc;
	pos_t       pos;

	// ------------------------------
	// Button sampling
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp_new <= '0;
			smp_old <= '0;
			eval    <= 1'b0;
		end else begin
			eval <= i_key_tick;
			if (i_key_tick) begin
				smp_new <= {i_btn_inc, i_btn_pos, i_btn_mode};
				smp_old <= smp_new;
			end
		end
	end

	// Rising edge, looked at once per key tick
	assign press_mode = eval & smp_new[0] & ~smp_old[0];
	assign press_pos  = eval & smp_new[1] & ~smp_old[1];
	assign press_inc  = eval & smp_new[2] & ~smp_old[2];

	// ------------------------------
	// Mode, position and strobes
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= MODE_RUN;
			pos        <= POS_SEC;
			o_inc_sec  <= 1'b0;
			o_inc_min  <= 1'b0;
			o_inc_hour <= 1'b0;
		end else begin
			o_inc_sec  <= 1'b0;
			o_inc_min  <= 1'b0;
			o_inc_hour <= 1'b0;
			if (press_mode) begin
				o_mode <= (o_mode == MODE_RUN) ? MODE_SET : MODE_RUN;
			end
			if (o_mode == MODE_SET) begin
				if (press_pos) begin
					case (pos)
						POS_SEC: pos <= POS_MIN;
						POS_MIN: pos <= POS_HOUR;
						default: pos <= POS_SEC;
					endcase
				end
				// Only the selected field gets the strobe
				if (press_inc) begin
					o_inc_sec  <= (pos == POS_SEC);
					o_inc_min  <= (pos == POS_MIN);
					o_inc_hour <= (pos == POS_HOUR);
				end
			end
		end
	end

	// Set mode lights the right dot of the selected field
	always_comb begin
		o_dp_mask = DP_RUN;
		if (o_mode == MODE_SET) begin
			case (pos)
				POS_MIN:  o_dp_mask = 6'b000100;
				POS_HOUR: o_dp_mask = 6'b010000;
				default:  o_dp_mask = 6'b000001;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hms_counter.sv
`timescale 1ns/1ps
`default_nettype none

module hms_counter import clock_pkg::*; (
	input  wire    clk,
	input  wire    rst_n,
	input  logic   i_sec_tick,
	input  mode_t  i_mode,
	input  logic   i_inc_sec,
	input  logic   i_inc_min,
	input  logic   i_inc_hour,
	output field_t o_sec,
	output field_t o_min,
	output field_t o_hour
);

	// Next value with wrap at the inclusive limit
	function automatic field_t wrap_inc(input field_t val, input field_t lim);
		return (val >= lim) ? '0 : val + 1'b1;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec  <= '0;
			o_min  <= '0;
			o_hour <= '0;
		end else if (i_mode == MODE_RUN) begin
			// Carry ripples through all fields in one cycle
			if (i_sec_tick) begin
				o_sec <= wrap_inc(o_sec, SEC_MAX);
				if (o_sec >= SEC_MAX) begin
					o_min <= wrap_inc(o_min, MIN_MAX);
					if (o_min >= MIN_MAX) begin
						o_hour <= wrap_inc(o_hour, HOUR_MAX);
					end
				end
			end
		end else begin
			// Set mode, no carry between fields
			if (i_inc_sec) begin
				o_sec <= wrap_inc(o_sec, SEC_MAX);
			end
			if (i_inc_min) begin
				o_min <= wrap_inc(o_min, MIN_MAX);
			end
			if (i_inc_hour) begin
				o_hour <= wrap_inc(o_hour, HOUR_MAX);
			end
		end
	end

endmodule

`default_nettype wire

//--- seg_frame.sv
`timescale 1ns/1ps
`default_nettype none

module seg_frame import clock_pkg::*; (
	input  wire                   clk,
	input  wire                   rst_n,
	input  field_t                i_sec,
	input  field_t                i_min,
	input  field_t                i_hour,
	input  dp_mask_t              i_dp_mask,
	output seg_t [NUM_DIGITS-1:0] o_frame_seg,
	output dp_mask_t              o_frame_dp
);

	bcd_t [NUM_DIGITS-1:0] digit;

	function automatic seg_t seg_decode(input bcd_t num);
		case (num)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;
		endcase
	endfunction

	// Index 0 is the right digit of the seconds
	always_comb begin
		digit[0] = bcd_t'(i_sec % 10);
		digit[1] = bcd_t'(i_sec / 10);
		digit[2] = bcd_t'(i_min % 10);
		digit[3] = bcd_t'(i_min / 10);
		digit[4] = bcd_t'(i_hour % 10);
		digit[5] = bcd_t'(i_hour / 10);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_frame_seg <= '0;
			o_frame_dp  <= '0;
		end else begin
			for (int k = 0; k < NUM_DIGITS; k++) begin
				o_frame_seg[k] <= seg_decode(digit[k]);
			end
			o_frame_dp <= i_dp_mask;
		end
	end

endmodule

`default_nettype wire

//--- digit_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module digit_scanner import clock_pkg::*; (
	input  wire                   clk,
	input  wire                   rst_n,
	input  logic                  i_scan_tick,
	input  seg_t [NUM_DIGITS-1:0] i_frame_seg,
	input  dp_mask_t              i_frame_dp,
	output seg_t                  o_seg,
	output logic                  o_seg_dp,
	output digit_en_t             o_seg_enb
);

	logic [$clog2(NUM_DIGITS)-1:0] idx;

	// ------------------------------
	// Digit multiplexing
	// ------------------------------
	// All digits dark until the first scan tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx       <= '0;
			o_seg     <= '0;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= '1;
		end else if (i_scan_tick) begin
			o_seg     <= i_frame_seg[idx];
			o_seg_dp  <= i_frame_dp[idx];
			o_seg_enb <= ~(digit_en_t'(1) << idx);
			if (idx == NUM_DIGITS - 1) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- clock_top.sv
`timescale 1ns/1ps
`default_nettype none

module clock_top import clock_pkg::*; #(
	parameter int CLK_PER_SEC  = CLK_PER_SEC_DEF,
	parameter int CLK_PER_SCAN = CLK_PER_SCAN_DEF,
	parameter int CLK_PER_KEY  = CLK_PER_KEY_DEF
) (
	input  wire       clk,
	input  wire       rst_n,
	input  logic      i_btn_mode,
	input  logic      i_btn_pos,
	input  logic      i_btn_inc,
	output seg_t      o_seg,
	output logic      o_seg_dp,
	output digit_en_t o_seg_enb
);

	logic                  sec_tick;
	logic                  scan_tick;
	logic                  key_tick;
	mode_t                 mode;
	logic                  inc_sec;
	logic                  inc_min;
	logic                  inc_hour;
	dp_mask_t              dp_mask;
	field_t                sec;
	field_t                min;
	field_t                hour;
	seg_t [NUM_DIGITS-1:0] frame_seg;
	dp_mask_t              frame_dp;

	// ------------------------------
	// Enable pulses
	// ------------------------------
	tick_gen #(.DIV(CLK_PER_SEC)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIV(CLK_PER_SCAN)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	tick_gen #(.DIV(CLK_PER_KEY)) u_key_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (key_tick)
	);

	key_ctrl u_key_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_btn_mode (i_btn_mode),
		.i_btn_pos  (i_btn_pos),
		.i_btn_inc  (i_btn_inc),
		.i_key_tick (key_tick),
		.o_mode     (mode),
		.o_inc_sec  (inc_sec),
		.o_inc_min  (inc_min),
		.o_inc_hour (inc_hour),
		.o_dp_mask  (dp_mask)
	);

	hms_counter u_hms_counter (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sec_tick (sec_tick),
		.i_mode     (mode),
		.i_inc_sec  (inc_sec),
		.i_inc_min  (inc_min),
		.i_inc_hour (inc_hour),
		.o_sec      (sec),
		.o_min      (min),
		.o_hour     (hour)
	);

	seg_frame u_seg_frame (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec       (sec),
		.i_min       (min),
		.i_hour      (hour),
		.i_dp_mask   (dp_mask),
		.o_frame_seg (frame_seg),
		.o_frame_dp  (frame_dp)
	);

	digit_scanner u_digit_scanner (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_frame_seg (frame_seg),
		.i_frame_dp  (frame_dp),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

`default_nettype wire

//--- clock_checker.sv
`timescale 1ns/1ps
`default_nettype none

module clock_checker import clock_pkg::*; (
	input  wire       clk,
	input  wire       rst_n,
	input  logic      i_scan_tick,
	input  digit_en_t i_seg_enb
);

	// Set once the scanner has taken its first step
	logic started;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			started <= 1'b0;
		end else if (i_scan_tick) begin
			started <= 1'b1;
		end
	end

	// No digit lit until the scanner has stepped once
	a_dark_before_scan: assert property (@(posedge clk) disable iff (!rst_n)
		!started |-> i_seg_enb == '1)
		else $error("a digit was enabled before the first scan tick");

	a_exactly_one: assert property (@(posedge clk) disable iff (!rst_n)
		started |-> $countones(~i_seg_enb) == 1)
		else $error("scanning display does not have exactly one digit enabled");

	a_step_on_tick: assert property (@(posedge clk) disable iff (!rst_n)
		!$stable(i_seg_enb) |-> $past(i_scan_tick))
		else $error("digit enables changed without a preceding scan tick");

endmodule

bind digit_scanner clock_checker u_clock_checker (
	.clk         (clk),
	.rst_n       (rst_n),
	.i_scan_tick (i_scan_tick),
	.i_seg_enb   (o_seg_enb)
);

`default_nettype wire

//--- tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock import clock_pkg::*;;

	localparam int SEC_DIV  = 2000;
	localparam int SCAN_DIV = 8;
	localparam int KEY_DIV  = 4;
	localparam int CLK_HALF = 4;
	localparam int unsigned SEED = 32'he8c8e393;

	// Segments a..g, digits 0 to 9
	localparam seg_t SEG_TABLE [10] = '{7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001,
		7'b0110011, 7'b1011011, 7'b1011111, 7'b1110000, 7'b1111111, 7'b1110011};

	typedef enum {ACT_MODE, ACT_POS, ACT_INC, ACT_RUN} act_t;
	typedef struct {
		string    name;
		act_t     act;
		int       count;
		field_t   hour;
		field_t   min;
		field_t   sec;
		dp_mask_t dots;
	} row_t;

	logic      clk;
	logic      rst_n;
	logic      btn_mode;
	logic      btn_pos;
	logic      btn_inc;
	seg_t      seg;
	logic      seg_dp;
	digit_en_t seg_enb;
	int        cycle_cnt = 0;
	row_t      rows[$];

	clock_top #(.CLK_PER_SEC(SEC_DIV), .CLK_PER_SCAN(SCAN_DIV), .CLK_PER_KEY(KEY_DIV)) UUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_btn_mode (btn_mode),
		.i_btn_pos  (btn_pos),
		.i_btn_inc  (btn_inc),
		.o_seg      (seg),
		.o_seg_dp   (seg_dp),
		.o_seg_enb  (seg_enb)
	);

	always #(CLK_HALF) clk = ~clk;

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_field(input string name, input string what, input field_t exp,
			input field_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("MISMATCH %s %s expected %0d actual %0d",
				name, what, exp, act));
		end
	endtask

	task automatic check_dots(input string name, input dp_mask_t exp, input dp_mask_t act);
		if (act !== exp) begin
			stop_on_error($sformatf("MISMATCH %s dots expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic add_row(input string name, input act_t act, input int count,
			input int hour, input int min, input int sec, input dp_mask_t dots);
		rows.push_back('{name, act, count, field_t'(hour), field_t'(min), field_t'(sec), dots});
	endtask

	task automatic wait_clocks(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
		end
	endtask

	// Returns -1 for a pattern that is not a digit
	function automatic int decode_seg(input seg_t pat);
		int val;
		val = -1;
		for (int n = 0; n < 10; n++) begin
			if (SEG_TABLE[n] == pat) val = n;
		end
		return val;
	endfunction

	task automatic press_button(input act_t act);
		int hold;
		hold = 3 + int'($urandom % 4);
		@(posedge clk);
		#1;
		btn_mode = (act == ACT_MODE);
		btn_pos  = (act == ACT_POS);
		btn_inc  = (act == ACT_INC);
		wait_clocks(hold * KEY_DIV);
		#1;
		btn_mode = 1'b0;
		btn_pos  = 1'b0;
		btn_inc  = 1'b0;
		wait_clocks(8 * KEY_DIV);
	endtask

	// One pass of the scan, every digit seen at least once
	task automatic capture_frame(output seg_t [NUM_DIGITS-1:0] segs, output dp_mask_t dots);
		dp_mask_t seen;
		int       waited;
		seen   = '0;
		waited = 0;
		segs   = '0;
		dots   = '0;
		while (seen != '1) begin
			@(negedge clk);
			waited++;
			if (waited > 4 * NUM_DIGITS * SCAN_DIV) begin
				stop_on_error("display scan did not visit every digit in time");
			end
			if ($countones(~seg_enb) == 1) begin
				for (int k = 0; k < NUM_DIGITS; k++) begin
					if (!seg_enb[k]) begin
						segs[k] = seg;
						dots[k] = seg_dp;
						seen[k] = 1'b1;
					end
				end
			end
		end
	endtask

	task automatic read_frame(input string name, output field_t hour, output field_t min,
			output field_t sec, output dp_mask_t dots);
		seg_t [NUM_DIGITS-1:0] prev_segs;
		seg_t [NUM_DIGITS-1:0] segs;
		dp_mask_t              prev_dots;
		int                    tries;
		int                    d [NUM_DIGITS];
		capture_frame(prev_segs, prev_dots);
		capture_frame(segs, dots);
		tries = 0;
		while (segs != prev_segs || dots != prev_dots) begin
			tries++;
			if (tries > 10) begin
				stop_on_error($sformatf("%s: display never showed two equal frames", name));
			end
			prev_segs = segs;
			prev_dots = dots;
			capture_frame(segs, dots);
		end
		for (int k = 0; k < NUM_DIGITS; k++) begin
			d[k] = decode_seg(segs[k]);
			if (d[k] < 0) begin
				stop_on_error($sformatf("%s: digit %0d shows no valid number", name, k));
			end
		end
		sec  = field_t'(d[1] * 10 + d[0]);
		min  = field_t'(d[3] * 10 + d[2]);
		hour = field_t'(d[5] * 10 + d[4]);
	endtask

	// Poll the display until it matches, at most five seconds of clocks
	task automatic expect_display(input row_t r);
		field_t   hour;
		field_t   min;
		field_t   sec;
		dp_mask_t dots;
		int       start;
		bit       done;
		start = cycle_cnt;
		done  = 1'b0;
		while (!done) begin
			read_frame(r.name, hour, min, sec, dots);
			if (hour == r.hour && min == r.min && sec == r.sec && dots == r.dots) begin
				done = 1'b1;
			end else if (cycle_cnt - start > 5 * SEC_DIV) begin
				done = 1'b1;
			end
		end
		check_field(r.name, "hour", r.hour, hour);
		check_field(r.name, "minute", r.min, min);
		check_field(r.name, "second", r.sec, sec);
		check_dots(r.name, r.dots, dots);
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		btn_mode = 1'b0;
		btn_pos  = 1'b0;
		btn_inc  = 1'b0;
		void'($urandom(SEED));
		// Name, action, count, hour, minute, second, dots
		add_row("reset_value",   ACT_RUN,   0,  0,  0,  0, DP_RUN);
		add_row("enter_set",     ACT_MODE,  1,  0,  0,  0, 6'b000001);
		add_row("select_min",    ACT_POS,   1,  0,  0,  0, 6'b000100);
		add_row("select_hour",   ACT_POS,   1,  0,  0,  0, 6'b010000);
		add_row("select_sec",    ACT_POS,   1,  0,  0,  0, 6'b000001);
		add_row("leave_set",     ACT_MODE,  1,  0,  0,  0, DP_RUN);
		add_row("reenter_set",   ACT_MODE,  1,  0,  0,  0, 6'b000001);
		add_row("sec_to_58",     ACT_INC,  58,  0,  0, 58, 6'b000001);
		add_row("sec_wrap",      ACT_INC,   2,  0,  0,  0, 6'b000001);
		add_row("sec_back_58",   ACT_INC,  58,  0,  0, 58, 6'b000001);
		add_row("select_min_2",  ACT_POS,   1,  0,  0, 58, 6'b000100);
		add_row("min_to_59",     ACT_INC,  59,  0, 59, 58, 6'b000100);
		add_row("select_hour_2", ACT_POS,   1,  0, 59, 58, 6'b010000);
		add_row("hour_to_23",    ACT_INC,  23, 23, 59, 58, 6'b010000);
		add_row("set_frozen",    ACT_RUN,   2, 23, 59, 58, 6'b010000);
		add_row("run_rollover",  ACT_MODE,  1,  0,  0,  1, DP_RUN);
		add_row("keep_running",  ACT_RUN,   0,  0,  0,  2, DP_RUN);
		wait_clocks(8);
		#1;
		rst_n = 1'b1;
		foreach (rows[i]) begin
			if (rows[i].act == ACT_RUN) begin
				wait_clocks(rows[i].count * SEC_DIV);
			end else begin
				for (int n = 0; n < rows[i].count; n++) begin
					press_button(rows[i].act);
				end
			end
			expect_display(rows[i]);
		end
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
clock_pkg.sv
tick_gen.sv
key_ctrl.sv
hms_counter.sv
seg_frame.sv
digit_scanner.sv
clock_top.sv
clock_checker.sv
tb_clock.sv

//--- run.sh
#!/bin/sh
# Build and run the wall clock testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_clock -f project.f \
	--Mdir obj_dir -o tb_clock
./obj_dir/tb_clock
